// ==== filelist.f ====
rtl/mgmt_pkg.sv
rtl/mgmt_access_if.sv
rtl/mgmt_addr_decode.sv
rtl/mgmt_write_exec.sv
rtl/mgmt_read_mux.sv
rtl/mgmt_regs_top.sv
verif/tb_mgmt_regs.sv

// ==== rtl/mgmt_access_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mgmt_access_if;

	// Read side, valid whenever a read is active
	mgmt_pkg::reg_region_t rd_region;
	mgmt_pkg::port_idx_t   rd_unit;
	mgmt_pkg::reg_off_t    rd_offset;

	// Write side, qualified by wr_en
	logic                  wr_en;
	mgmt_pkg::reg_region_t wr_region;
	mgmt_pkg::port_idx_t   wr_unit;
	mgmt_pkg::reg_off_t    wr_offset;
	mgmt_pkg::reg_data_t   wr_data;

	modport decoder(
		output rd_region, rd_unit, rd_offset,
		output wr_en, wr_region, wr_unit, wr_offset, wr_data
	);

	modport execute(input wr_en, wr_region, wr_unit, wr_offset, wr_data);

	modport result(input rd_region, rd_unit, rd_offset);

endinterface

`default_nettype wire

// ==== rtl/mgmt_addr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mgmt_addr_decode(
	input  mgmt_pkg::reg_addr_t rd_addr,
	input  logic                wr_en,
	input  mgmt_pkg::reg_addr_t wr_addr,
	input  mgmt_pkg::reg_data_t wr_data,
	mgmt_access_if.decoder      acc
);

	// Split one address into region, unit and byte offset
	// Unsigned wrap makes a single compare per region a full range check
	function automatic void classify(
		input  mgmt_pkg::reg_addr_t   addr,
		output mgmt_pkg::reg_region_t region,
		output mgmt_pkg::port_idx_t   unit,
		output mgmt_pkg::reg_off_t    offset
	);
		mgmt_pkg::reg_addr_t rel_id;
		mgmt_pkg::reg_addr_t rel_sn;
		mgmt_pkg::reg_addr_t rel_sens;
		mgmt_pkg::reg_addr_t rel_mdio;
		mgmt_pkg::reg_addr_t rel_port;
		rel_id   = addr - mgmt_pkg::REG_IDCODE_BASE;
		rel_sn   = addr - mgmt_pkg::REG_SERIAL_BASE;
		rel_sens = addr - mgmt_pkg::REG_SENSOR_BASE;
		rel_mdio = addr - mgmt_pkg::REG_MDIO_BASE;
		rel_port = addr - mgmt_pkg::REG_PORT_BASE;

		// Unmapped unless a region claims it
		region = mgmt_pkg::REGION_NONE;
		unit   = '0;
		offset = '0;

		if (rel_id < mgmt_pkg::IDCODE_SPAN) begin
			region = mgmt_pkg::REGION_IDCODE;
			offset = mgmt_pkg::reg_off_t'(rel_id);
		end else if (rel_sn < mgmt_pkg::SERIAL_SPAN) begin
			region = mgmt_pkg::REGION_SERIAL;
			offset = mgmt_pkg::reg_off_t'(rel_sn);
		end else if (rel_sens < mgmt_pkg::SENSOR_SPAN) begin
			// Two bytes per sensor
			region = mgmt_pkg::REGION_SENSOR;
			unit   = mgmt_pkg::port_idx_t'(rel_sens >> 1);
			offset = mgmt_pkg::reg_off_t'(rel_sens[0]);
		end else if (rel_mdio < mgmt_pkg::MDIO_SPAN) begin
			// Four bytes per channel
			region = mgmt_pkg::REGION_MDIO;
			unit   = mgmt_pkg::port_idx_t'(rel_mdio >> 2);
			offset = mgmt_pkg::reg_off_t'(rel_mdio[1:0]);
		end else if (rel_port < mgmt_pkg::PORT_SPAN) begin
			// Port 15 and above falls outside the span
			region = mgmt_pkg::REGION_PORT;
			unit   = rel_port[mgmt_pkg::PORT_STRIDE_BITS +: 4];
			offset = rel_port[mgmt_pkg::PORT_STRIDE_BITS-1:0];
		end
	endfunction

	always_comb begin
		classify(rd_addr, acc.rd_region, acc.rd_unit, acc.rd_offset);
		classify(wr_addr, acc.wr_region, acc.wr_unit, acc.wr_offset);
	end

	// Write strobe and data go straight through with the decode
	assign acc.wr_en   = wr_en;
	assign acc.wr_data = wr_data;

endmodule

`default_nettype wire

// ==== rtl/mgmt_pkg.sv ====
`default_nettype none

package mgmt_pkg;

	//////////////////////////////////////////////////////////////
	// Widths

	typedef logic [15:0] reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [11:0] vlan_t;
	typedef logic [4:0]  phy_addr_t;
	typedef logic [15:0] phy_data_t;
	typedef logic [15:0] sensor_t;
	typedef logic [3:0]  port_idx_t;

	// Byte offset inside one unit, sized for the widest unit (a port)
	localparam int PORT_STRIDE_BITS = 10;
	typedef logic [PORT_STRIDE_BITS-1:0] reg_off_t;

	// Address classes seen by the decoder
	typedef enum logic [2:0] {
		REGION_IDCODE,
		REGION_SERIAL,
		REGION_SENSOR,
		REGION_MDIO,
		REGION_PORT,
		REGION_NONE
	} reg_region_t;

	//////////////////////////////////////////////////////////////
	// Counts

	localparam int NUM_PORTS       = 15;
	// 0 = management, 1 = data plane, 2 = switch chip
	localparam int MDIO_CHANNELS   = 3;
	// fan0, fan1, die temp, core V, RAM V, aux V
	localparam int NUM_SENSORS     = 6;
	localparam int MDIO_SEL_BITS   = $clog2(MDIO_CHANNELS);
	localparam int SENSOR_SEL_BITS = $clog2(NUM_SENSORS);

	//////////////////////////////////////////////////////////////
	// Register map

	localparam reg_addr_t REG_IDCODE_BASE = 16'h0000;
	localparam reg_addr_t REG_SERIAL_BASE = 16'h0004;
	localparam reg_addr_t REG_SENSOR_BASE = 16'h0010;
	localparam reg_addr_t REG_MDIO_BASE   = 16'h0048;
	localparam reg_addr_t REG_PORT_BASE   = 16'h4000;

	// Size of each region in bytes
	localparam reg_addr_t IDCODE_SPAN = 16'd4;
	localparam reg_addr_t SERIAL_SPAN = 16'd8;
	localparam reg_addr_t SENSOR_SPAN = reg_addr_t'(NUM_SENSORS * 2);
	localparam reg_addr_t MDIO_SPAN   = reg_addr_t'(MDIO_CHANNELS * 4);
	localparam reg_addr_t PORT_SPAN   = reg_addr_t'(NUM_PORTS << PORT_STRIDE_BITS);

	// Offsets inside a port block
	localparam reg_off_t PORT_OFF_VLAN_LO  = 10'd0;
	localparam reg_off_t PORT_OFF_VLAN_HI  = 10'd1;
	localparam reg_off_t PORT_OFF_TAG_MODE = 10'd2;

	// Offsets inside an MDIO block
	localparam reg_off_t MDIO_OFF_DATA_LO = 10'd0;
	localparam reg_off_t MDIO_OFF_DATA_HI = 10'd1;
	localparam reg_off_t MDIO_OFF_ADDR    = 10'd2;
	localparam reg_off_t MDIO_OFF_CTRL    = 10'd3;

	// Bit positions in tag-mode and MDIO control bytes
	localparam int TAG_ALLOW_TAGGED_BIT   = 0;
	localparam int TAG_ALLOW_UNTAGGED_BIT = 1;
	localparam int TAG_TRUNK_BIT          = 4;
	localparam int MDIO_RD_BIT            = 5;
	localparam int MDIO_WR_BIT            = 6;
	localparam int MDIO_BUSY_BIT          = 7;

endpackage

`default_nettype wire

// ==== rtl/mgmt_read_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module mgmt_read_mux(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rd_en,
	mgmt_access_if.result       acc,

	// Die identity, each with its own valid flag
	input  logic [31:0]         idcode,
	input  logic                idcode_valid,
	input  logic [63:0]         die_serial,
	input  logic                die_serial_valid,

	input  mgmt_pkg::sensor_t   [mgmt_pkg::NUM_SENSORS-1:0]   sensors,
	input  mgmt_pkg::phy_data_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_rd_data,
	input  logic                [mgmt_pkg::MDIO_CHANNELS-1:0] mdio_busy,

	output logic                rd_valid,
	output mgmt_pkg::reg_data_t rd_data
);

	//////////////////////////////////////////////////////////////
	// Completion control

	// Set while a read waits on identity data
	logic pending;
	logic active;
	logic stall;

	assign active = rd_en || pending;

	// Hold off only if the addressed identity value is not yet valid
	assign stall = ((acc.rd_region == mgmt_pkg::REGION_IDCODE) && !idcode_valid) ||
		((acc.rd_region == mgmt_pkg::REGION_SERIAL) && !die_serial_valid);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending  <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			pending  <= active && stall;
			rd_valid <= active && !stall;
		end
	end

	//////////////////////////////////////////////////////////////
	// Byte select

	logic [mgmt_pkg::MDIO_SEL_BITS-1:0]   ch;
	logic [mgmt_pkg::SENSOR_SEL_BITS-1:0] sens;
	mgmt_pkg::reg_data_t                  sel_byte;

	assign ch   = acc.rd_unit[mgmt_pkg::MDIO_SEL_BITS-1:0];
	assign sens = acc.rd_unit[mgmt_pkg::SENSOR_SEL_BITS-1:0];

	always_comb begin
		sel_byte = '0;
		case (acc.rd_region)
			// Identity is MSB first, so invert the byte index
			mgmt_pkg::REGION_IDCODE: sel_byte = idcode[{~acc.rd_offset[1:0], 3'b000} +: 8];
			mgmt_pkg::REGION_SERIAL: sel_byte = die_serial[{~acc.rd_offset[2:0], 3'b000} +: 8];
			// Sensors little endian
			mgmt_pkg::REGION_SENSOR: sel_byte = sensors[sens][{acc.rd_offset[0], 3'b000} +: 8];
			mgmt_pkg::REGION_MDIO: begin
				case (acc.rd_offset)
					mgmt_pkg::MDIO_OFF_DATA_LO: sel_byte = phy_rd_data[ch][7:0];
					mgmt_pkg::MDIO_OFF_DATA_HI: sel_byte = phy_rd_data[ch][15:8];
					mgmt_pkg::MDIO_OFF_CTRL:    sel_byte[mgmt_pkg::MDIO_BUSY_BIT] = mdio_busy[ch];
					default:                    sel_byte = '0;
				endcase
			end
			// Port config has no readback, unmapped reads zero
			default: sel_byte = '0;
		endcase
	end

	// Capture the byte on the completing cycle only
	always_ff @(posedge clk) begin
		if (active && !stall)
			rd_data <= sel_byte;
	end

endmodule

`default_nettype wire

// ==== rtl/mgmt_regs_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mgmt_regs_top(
	input  logic                clk,
	input  logic                rst_n,

	// Register bus
	input  logic                rd_en,
	input  mgmt_pkg::reg_addr_t rd_addr,
	output logic                rd_valid,
	output mgmt_pkg::reg_data_t rd_data,
	input  logic                wr_en,
	input  mgmt_pkg::reg_addr_t wr_addr,
	input  mgmt_pkg::reg_data_t wr_data,

	// Die identity
	input  logic [31:0]         idcode,
	input  logic                idcode_valid,
	input  logic [63:0]         die_serial,
	input  logic                die_serial_valid,

	input  mgmt_pkg::sensor_t   [mgmt_pkg::NUM_SENSORS-1:0]   sensors,

	// MDIO controllers
	output mgmt_pkg::phy_addr_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_addr,
	output mgmt_pkg::phy_addr_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_md_addr,
	output mgmt_pkg::phy_data_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_wr_data,
	output logic                [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_rd,
	output logic                [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_wr,
	input  mgmt_pkg::phy_data_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_rd_data,
	input  logic                [mgmt_pkg::MDIO_CHANNELS-1:0] mdio_busy,

	// Port configuration
	output mgmt_pkg::vlan_t     [mgmt_pkg::NUM_PORTS-1:0]     port_vlan,
	output logic                [mgmt_pkg::NUM_PORTS-1:0]     port_tagged_allowed,
	output logic                [mgmt_pkg::NUM_PORTS-1:0]     port_untagged_allowed,
	output logic                [mgmt_pkg::NUM_PORTS-1:0]     port_is_trunk
);

	// Decoded accesses shared by execute and result
	mgmt_access_if acc();

	mgmt_addr_decode u_decode(
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.acc(acc.decoder)
	);

	mgmt_write_exec u_exec(
		.clk(clk),
		.rst_n(rst_n),
		.acc(acc.execute),
		.phy_reg_addr(phy_reg_addr),
		.phy_md_addr(phy_md_addr),
		.phy_wr_data(phy_wr_data),
		.phy_reg_rd(phy_reg_rd),
		.phy_reg_wr(phy_reg_wr),
		.port_vlan(port_vlan),
		.port_tagged_allowed(port_tagged_allowed),
		.port_untagged_allowed(port_untagged_allowed),
		.port_is_trunk(port_is_trunk)
	);

	mgmt_read_mux u_result(
		.clk(clk),
		.rst_n(rst_n),
		.rd_en(rd_en),
		.acc(acc.result),
		.idcode(idcode),
		.idcode_valid(idcode_valid),
		.die_serial(die_serial),
		.die_serial_valid(die_serial_valid),
		.sensors(sensors),
		.phy_rd_data(phy_rd_data),
		.mdio_busy(mdio_busy),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

// ==== rtl/mgmt_write_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module mgmt_write_exec(
	input  logic                  clk,
	input  logic                  rst_n,
	mgmt_access_if.execute        acc,

	// MDIO command outputs, one entry per channel
	output mgmt_pkg::phy_addr_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_addr,
	output mgmt_pkg::phy_addr_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_md_addr,
	output mgmt_pkg::phy_data_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_wr_data,
	output logic                [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_rd,
	output logic                [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_wr,

	// Per-port configuration
	output mgmt_pkg::vlan_t     [mgmt_pkg::NUM_PORTS-1:0]     port_vlan,
	output logic                [mgmt_pkg::NUM_PORTS-1:0]     port_tagged_allowed,
	output logic                [mgmt_pkg::NUM_PORTS-1:0]     port_untagged_allowed,
	output logic                [mgmt_pkg::NUM_PORTS-1:0]     port_is_trunk
);

	// Channel select, range already checked by the decoder
	logic [mgmt_pkg::MDIO_SEL_BITS-1:0] ch;
	assign ch = acc.wr_unit[mgmt_pkg::MDIO_SEL_BITS-1:0];

	logic mdio_wr;
	logic port_wr;
	assign mdio_wr = acc.wr_en && (acc.wr_region == mgmt_pkg::REGION_MDIO);
	assign port_wr = acc.wr_en && (acc.wr_region == mgmt_pkg::REGION_PORT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phy_reg_addr          <= '0;
			phy_md_addr           <= '0;
			phy_wr_data           <= '0;
			phy_reg_rd            <= '0;
			phy_reg_wr            <= '0;
			port_vlan             <= '0;
			port_tagged_allowed   <= '0;
			port_untagged_allowed <= '0;
			port_is_trunk         <= '0;
		end else begin
			// Strobes last one cycle unless the control byte sets them
			phy_reg_rd <= '0;
			phy_reg_wr <= '0;

			//////////////////////////////////////////////////////////////
			// MDIO command registers

			if (mdio_wr) begin
				case (acc.wr_offset)
					mgmt_pkg::MDIO_OFF_DATA_LO: phy_wr_data[ch][7:0]  <= acc.wr_data;
					mgmt_pkg::MDIO_OFF_DATA_HI: phy_wr_data[ch][15:8] <= acc.wr_data;
					mgmt_pkg::MDIO_OFF_ADDR: begin
						// Register address low, PHY address bits 2:0 high
						phy_reg_addr[ch]     <= acc.wr_data[4:0];
						phy_md_addr[ch][2:0] <= acc.wr_data[7:5];
					end
					mgmt_pkg::MDIO_OFF_CTRL: begin
						phy_md_addr[ch][4:3] <= acc.wr_data[1:0];
						phy_reg_rd[ch]       <= acc.wr_data[mgmt_pkg::MDIO_RD_BIT];
						phy_reg_wr[ch]       <= acc.wr_data[mgmt_pkg::MDIO_WR_BIT];
					end
					default: ;
				endcase
			end

			//////////////////////////////////////////////////////////////
			// Port configuration

			if (port_wr) begin
				case (acc.wr_offset)
					mgmt_pkg::PORT_OFF_VLAN_LO: port_vlan[acc.wr_unit][7:0] <= acc.wr_data;
					// Only the low nibble is meaningful in the high byte
					mgmt_pkg::PORT_OFF_VLAN_HI: port_vlan[acc.wr_unit][11:8] <= acc.wr_data[3:0];
					mgmt_pkg::PORT_OFF_TAG_MODE: begin
						port_tagged_allowed[acc.wr_unit] <=
							acc.wr_data[mgmt_pkg::TAG_ALLOW_TAGGED_BIT];
						port_untagged_allowed[acc.wr_unit] <=
							acc.wr_data[mgmt_pkg::TAG_ALLOW_UNTAGGED_BIT];
						port_is_trunk[acc.wr_unit] <= acc.wr_data[mgmt_pkg::TAG_TRUNK_BIT];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f filelist.f --top-module tb_mgmt_regs -o tb_mgmt_regs \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_mgmt_regs > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

// ==== verif/tb_mgmt_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mgmt_regs;

	localparam int TIMEOUT_CYCLES = 50;

	logic                clk;
	logic                rst_n;
	logic                rd_en;
	mgmt_pkg::reg_addr_t rd_addr;
	logic                rd_valid;
	mgmt_pkg::reg_data_t rd_data;
	logic                wr_en;
	mgmt_pkg::reg_addr_t wr_addr;
	mgmt_pkg::reg_data_t wr_data;
	logic [31:0]         idcode;
	logic                idcode_valid;
	logic [63:0]         die_serial;
	logic                die_serial_valid;

	mgmt_pkg::sensor_t   [mgmt_pkg::NUM_SENSORS-1:0]   sensors;
	mgmt_pkg::phy_addr_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_addr;
	mgmt_pkg::phy_addr_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_md_addr;
	mgmt_pkg::phy_data_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_wr_data;
	logic                [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_rd;
	logic                [mgmt_pkg::MDIO_CHANNELS-1:0] phy_reg_wr;
	mgmt_pkg::phy_data_t [mgmt_pkg::MDIO_CHANNELS-1:0] phy_rd_data;
	logic                [mgmt_pkg::MDIO_CHANNELS-1:0] mdio_busy;
	mgmt_pkg::vlan_t     [mgmt_pkg::NUM_PORTS-1:0]     port_vlan;
	logic                [mgmt_pkg::NUM_PORTS-1:0]     port_tagged_allowed;
	logic                [mgmt_pkg::NUM_PORTS-1:0]     port_untagged_allowed;
	logic                [mgmt_pkg::NUM_PORTS-1:0]     port_is_trunk;

	// Register model holding a copy of every writable field
	mgmt_pkg::phy_addr_t m_reg_addr [mgmt_pkg::MDIO_CHANNELS];
	mgmt_pkg::phy_addr_t m_md_addr  [mgmt_pkg::MDIO_CHANNELS];
	mgmt_pkg::phy_data_t m_wr_data  [mgmt_pkg::MDIO_CHANNELS];
	logic [mgmt_pkg::MDIO_CHANNELS-1:0] m_rd_strobe;
	logic [mgmt_pkg::MDIO_CHANNELS-1:0] m_wr_strobe;
	mgmt_pkg::vlan_t     m_vlan     [mgmt_pkg::NUM_PORTS];
	logic [mgmt_pkg::NUM_PORTS-1:0] m_tagged;
	logic [mgmt_pkg::NUM_PORTS-1:0] m_untagged;
	logic [mgmt_pkg::NUM_PORTS-1:0] m_trunk;

	mgmt_regs_top UUT(.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input mgmt_pkg::reg_data_t got, exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
	endtask

	task automatic check_vlan(input string name, input mgmt_pkg::vlan_t got, exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
	endtask

	task automatic check_phy_data(input string name, input mgmt_pkg::phy_data_t got, exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
	endtask

	task automatic check_phy_addr(input string name, input mgmt_pkg::phy_addr_t got, exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// Every configuration output and strobe against the model
	task automatic check_outputs;
		logic [1:0]          c;
		mgmt_pkg::port_idx_t p;
		for (c = 2'd0; c < 2'd3; c = c + 2'd1) begin
			check_phy_addr($sformatf("phy_reg_addr[%0d]", c), phy_reg_addr[c], m_reg_addr[c]);
			check_phy_addr($sformatf("phy_md_addr[%0d]", c), phy_md_addr[c], m_md_addr[c]);
			check_phy_data($sformatf("phy_wr_data[%0d]", c), phy_wr_data[c], m_wr_data[c]);
			check_bit($sformatf("phy_reg_rd[%0d]", c), phy_reg_rd[c], m_rd_strobe[c]);
			check_bit($sformatf("phy_reg_wr[%0d]", c), phy_reg_wr[c], m_wr_strobe[c]);
		end
		for (p = 4'd0; p < 4'd15; p = p + 4'd1) begin
			check_vlan($sformatf("port_vlan[%0d]", p), port_vlan[p], m_vlan[p]);
			check_bit($sformatf("port_tagged_allowed[%0d]", p), port_tagged_allowed[p],
				m_tagged[p]);
			check_bit($sformatf("port_untagged_allowed[%0d]", p), port_untagged_allowed[p],
				m_untagged[p]);
			check_bit($sformatf("port_is_trunk[%0d]", p), port_is_trunk[p], m_trunk[p]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Model

	function automatic logic is_mapped(input mgmt_pkg::reg_addr_t a);
		return (a < 16'h000C) || (a >= 16'h0010 && a < 16'h001C) ||
			(a >= 16'h0048 && a < 16'h0054) || (a >= 16'h4000 && a < 16'h7C00);
	endfunction

	// Identity is MSB first while sensors and MDIO data are little endian
	function automatic mgmt_pkg::reg_data_t expected_byte(input mgmt_pkg::reg_addr_t a);
		mgmt_pkg::reg_addr_t rel;
		expected_byte = '0;
		if (a < 16'h0004) begin
			expected_byte = mgmt_pkg::reg_data_t'(idcode >> (8 * (3 - int'(a[1:0]))));
		end else if (a < 16'h000C) begin
			rel = a - 16'h0004;
			expected_byte = mgmt_pkg::reg_data_t'(die_serial >> (8 * (7 - int'(rel[2:0]))));
		end else if (a >= 16'h0010 && a < 16'h001C) begin
			rel = a - 16'h0010;
			expected_byte = mgmt_pkg::reg_data_t'(sensors[rel[3:1]] >> (8 * int'(rel[0])));
		end else if (a >= 16'h0048 && a < 16'h0054) begin
			rel = a - 16'h0048;
			case (rel[1:0])
				2'd0: expected_byte = phy_rd_data[rel[3:2]][7:0];
				2'd1: expected_byte = phy_rd_data[rel[3:2]][15:8];
				2'd3: expected_byte = {mdio_busy[rel[3:2]], 7'b0};
				default: expected_byte = '0;
			endcase
		end
	endfunction

	function automatic void model_write(input mgmt_pkg::reg_addr_t a,
		input mgmt_pkg::reg_data_t d);
		mgmt_pkg::reg_addr_t rel;
		mgmt_pkg::port_idx_t p;
		logic [1:0]          c;
		if (a >= 16'h0048 && a < 16'h0054) begin
			rel = a - 16'h0048;
			c = rel[3:2];
			case (rel[1:0])
				2'd0: m_wr_data[c][7:0] = d;
				2'd1: m_wr_data[c][15:8] = d;
				2'd2: begin
					m_reg_addr[c] = d[4:0];
					m_md_addr[c][2:0] = d[7:5];
				end
				default: begin
					m_md_addr[c][4:3] = d[1:0];
					m_rd_strobe[c] = d[5];
					m_wr_strobe[c] = d[6];
				end
			endcase
		end else if (a >= 16'h4000 && a < 16'h7C00) begin
			// Port 15 lands at 0x7C00 and is never reached
			rel = a - 16'h4000;
			p = rel[13:10];
			case (rel[9:0])
				10'd0: m_vlan[p][7:0] = d;
				10'd1: m_vlan[p][11:8] = d[3:0];
				10'd2: begin
					m_tagged[p] = d[0];
					m_untagged[p] = d[1];
					m_trunk[p] = d[4];
				end
				default: ;
			endcase
		end
	endfunction

	function automatic mgmt_pkg::reg_addr_t pick_unmapped();
		mgmt_pkg::reg_addr_t a;
		a = mgmt_pkg::reg_addr_t'($urandom);
		// Favour the gaps near the low regions half the time
		while (is_mapped(a)) begin
			if (($urandom & 1) != 0)
				a = mgmt_pkg::reg_addr_t'($urandom_range(0, 255));
			else
				a = mgmt_pkg::reg_addr_t'($urandom);
		end
		return a;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus tasks

	task automatic randomize_inputs;
		@(posedge clk);
		idcode      <= $urandom;
		die_serial  <= {$urandom, $urandom};
		sensors     <= {$urandom, $urandom, $urandom};
		phy_rd_data <= 48'({$urandom, $urandom});
		mdio_busy   <= 3'($urandom);
	endtask

	task automatic wait_read_done;
		int n;
		n = 0;
		@(negedge clk);
		while (!rd_valid) begin
			n++;
			if (n > TIMEOUT_CYCLES)
				report_failure("read never completed");
			else
				@(negedge clk);
		end
	endtask

	task automatic read_and_check(input mgmt_pkg::reg_addr_t a);
		@(posedge clk);
		rd_en   <= 1'b1;
		rd_addr <= a;
		@(posedge clk);
		rd_en <= 1'b0;
		wait_read_done();
		check_byte($sformatf("rd_data @0x%h", a), rd_data, expected_byte(a));
		// Valid is a single pulse
		@(negedge clk);
		check_bit("rd_valid", rd_valid, 1'b0);
	endtask

	// Strobes must be high in the cycle after the write and gone in the next
	task automatic bus_write(input mgmt_pkg::reg_addr_t a, input mgmt_pkg::reg_data_t d);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_addr <= a;
		wr_data <= d;
		@(posedge clk);
		wr_en <= 1'b0;
		model_write(a, d);
		@(negedge clk);
		check_outputs();
		m_rd_strobe = '0;
		m_wr_strobe = '0;
		@(negedge clk);
		check_outputs();
	endtask

	task automatic read_write_same_cycle(input mgmt_pkg::reg_addr_t ra, wa,
		input mgmt_pkg::reg_data_t d);
		@(posedge clk);
		rd_en   <= 1'b1;
		rd_addr <= ra;
		wr_en   <= 1'b1;
		wr_addr <= wa;
		wr_data <= d;
		@(posedge clk);
		rd_en <= 1'b0;
		wr_en <= 1'b0;
		model_write(wa, d);
		wait_read_done();
		check_byte($sformatf("rd_data @0x%h", ra), rd_data, expected_byte(ra));
		check_outputs();
	endtask

	// Identity read held off until its valid input rises
	task automatic stall_read(input mgmt_pkg::reg_addr_t a);
		@(posedge clk);
		idcode_valid     <= 1'b0;
		die_serial_valid <= 1'b0;
		rd_en            <= 1'b1;
		rd_addr          <= a;
		@(posedge clk);
		rd_en <= 1'b0;
		repeat (20) begin
			@(negedge clk);
			check_bit("rd_valid", rd_valid, 1'b0);
		end
		@(posedge clk);
		if (a < 16'h0004)
			idcode_valid <= 1'b1;
		else
			die_serial_valid <= 1'b1;
		wait_read_done();
		check_byte($sformatf("rd_data @0x%h", a), rd_data, expected_byte(a));
		@(posedge clk);
		idcode_valid     <= 1'b1;
		die_serial_valid <= 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int                  k;
		int                  c;
		int                  p;
		int                  off;
		mgmt_pkg::reg_addr_t a;
		void'($urandom(22782));
		rst_n            = 1'b0;
		rd_en            = 1'b0;
		rd_addr          = '0;
		wr_en            = 1'b0;
		wr_addr          = '0;
		wr_data          = '0;
		idcode           = '0;
		idcode_valid     = 1'b1;
		die_serial       = '0;
		die_serial_valid = 1'b1;
		sensors          = '0;
		phy_rd_data      = '0;
		mdio_busy        = '0;
		m_reg_addr       = '{default: '0};
		m_md_addr        = '{default: '0};
		m_wr_data        = '{default: '0};
		m_vlan           = '{default: '0};
		m_rd_strobe      = '0;
		m_wr_strobe      = '0;
		m_tagged         = '0;
		m_untagged       = '0;
		m_trunk          = '0;

		// Reset values
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("rd_valid", rd_valid, 1'b0);
		check_outputs();

		// Identity, sensor and MDIO readback
		for (k = 0; k < 60; k++) begin
			randomize_inputs();
			case ($urandom_range(0, 2))
				0: a = mgmt_pkg::reg_addr_t'($urandom_range(0, 11));
				1: a = mgmt_pkg::reg_addr_t'($urandom_range(16, 27));
				default: a = mgmt_pkg::reg_addr_t'($urandom_range(72, 83));
			endcase
			read_and_check(a);
		end
		for (k = 0; k < 6; k++) begin
			randomize_inputs();
			stall_read(mgmt_pkg::reg_addr_t'($urandom_range(0, 11)));
		end

		// MDIO commands
		for (k = 0; k < 60; k++) begin
			c   = $urandom_range(0, 2);
			off = $urandom_range(0, 3);
			a   = mgmt_pkg::REG_MDIO_BASE + mgmt_pkg::reg_addr_t'(4 * c + off);
			bus_write(a, mgmt_pkg::reg_data_t'($urandom));
			if (k % 4 == 3) begin
				randomize_inputs();
				read_and_check(mgmt_pkg::reg_addr_t'($urandom_range(72, 83)));
			end
		end

		// Port config including port 15 and unused offsets
		for (k = 0; k < 80; k++) begin
			p   = $urandom_range(0, 15);
			off = $urandom_range(0, 3);
			if (off == 3)
				off = $urandom_range(0, 1023);
			a = mgmt_pkg::REG_PORT_BASE + mgmt_pkg::reg_addr_t'((p << 10) + off);
			bus_write(a, mgmt_pkg::reg_data_t'($urandom));
			if (k % 5 == 4)
				read_and_check(a);
		end

		// Unmapped space
		for (k = 0; k < 30; k++) begin
			read_and_check(pick_unmapped());
			bus_write(pick_unmapped(), mgmt_pkg::reg_data_t'($urandom));
			read_write_same_cycle(pick_unmapped(), pick_unmapped(),
				mgmt_pkg::reg_data_t'($urandom));
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire
